/* list.f */
logic/mem_arb_pkg.sv
logic/rr_scheduler.sv
logic/beat_counter.sv
logic/line_assembler.sv
logic/request_path.sv
logic/mem_arbiter.sv
test/tb_mem_arbiter.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mem_arbiter
VFLAGS ?= --assert --timing

OBJ_DIR := obj_dir

.PHONY: sim clean

# build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

// four requesters and a burst memory model around the arbiter
module tb_mem_arbiter;

    localparam int num_ports = 4;
    localparam int clk_period = 4;
    localparam int num_trans = 64;
    // first resps checked for strict round-robin order
    localparam int order_len = 16;
    localparam int cycles_per_trans = 100;

    logic clk = 1'b0;
    logic rst;
    logic [num_ports-1:0] req_read;
    logic [num_ports-1:0] req_write;
    mem_arb_pkg::addr_t req_addr [num_ports];
    mem_arb_pkg::line_t req_wdata [num_ports];
    logic [num_ports-1:0] resp;
    mem_arb_pkg::line_t resp_rdata;
    mem_arb_pkg::addr_t bmem_addr;
    logic bmem_read;
    logic bmem_write;
    mem_arb_pkg::beat_t bmem_wdata;
    logic bmem_ready;
    mem_arb_pkg::beat_t bmem_rdata;
    logic bmem_rvalid;

    // memory contents and the expected view after each write resp
    mem_arb_pkg::line_t mem_lines [mem_arb_pkg::addr_t];
    mem_arb_pkg::line_t shadow [mem_arb_pkg::addr_t];
    // last writing port of each line
    int writer [mem_arb_pkg::addr_t];
    // reads of a line last written by another port
    int cross_reads = 0;
    logic [31:0] rng_state = 32'h256d948e;
    int check_failures = 0;
    int gap [num_ports];
    int issued = 0;
    int served = 0;

    // compare side state
    bit prev_rst = 1'b0;
    bit rd_stall = 1'b0;
    bit wr_stall = 1'b0;
    mem_arb_pkg::addr_t stall_addr;
    mem_arb_pkg::beat_t stall_beat;
    mem_arb_pkg::addr_t rd_cmd_addr;
    mem_arb_pkg::addr_t wr_cmd_addr;
    mem_arb_pkg::line_t wr_line;
    int beats = 0;
    int resp_total = 0;
    int exp_port = 0;

    mem_arbiter #(.num_ports(num_ports)) UUT (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // power-up content where every beat depends on the full address
    function automatic mem_arb_pkg::line_t fill_line(input mem_arb_pkg::addr_t a);
        mem_arb_pkg::line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*64 +: 64] = {a ^ (32'h9e3779b9 * (k + 1)), ~a + 32'(k)};
        end
        return l;
    endfunction

    function automatic mem_arb_pkg::line_t mem_line(input mem_arb_pkg::addr_t a);
        return mem_lines.exists(a) ? mem_lines[a] : fill_line(a);
    endfunction

    // expected read data is the last written line or the fill pattern
    function automatic mem_arb_pkg::line_t expected_line(input mem_arb_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_line(a);
    endfunction

    task automatic end_with_failure();
        check_failures++;
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [255:0] exp_v,
                                   input logic [255:0] got_v);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp_v, got_v);
        end_with_failure();
    endtask

    task automatic report_failure(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    // new line request on one of 8 lines shared by all ports
    task automatic raise_request(input int i);
        logic [31:0] r;
        r = next_rand();
        req_addr[i] = {16'h0004, 8'h00, r[7:5], 5'b0};
        req_read[i] = r[0];
        req_write[i] = !r[0];
        for (int k = 0; k < 8; k++) begin
            req_wdata[i][k*32 +: 32] = next_rand();
        end
        issued++;
    endtask

    initial begin : drive_main
        logic [num_ports-1:0] got;
        logic [31:0] r;
        int rd_left;
        int rd_idx;
        int wr_idx;
        mem_arb_pkg::line_t rd_line;
        mem_arb_pkg::line_t wr_buf;
        rd_left = 0;
        rd_idx = 0;
        wr_idx = 0;
        rst = 1'b1;
        req_read = '0;
        req_write = '0;
        bmem_ready = 1'b0;
        bmem_rdata = '0;
        bmem_rvalid = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            req_addr[i] = '0;
            req_wdata[i] = '0;
            gap[i] = 0;
        end
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        while (served < num_trans) begin
            @(posedge clk);
            got = resp;
            // memory model sees what the DUT saw at this edge
            if (bmem_rvalid) begin
                rd_left--;
                rd_idx++;
            end
            if (bmem_read && bmem_ready && rd_left == 0) begin
                rd_line = mem_line(bmem_addr);
                rd_left = 4;
                rd_idx = 0;
            end
            if (bmem_write && bmem_ready) begin
                wr_buf = mem_line(bmem_addr);
                wr_buf[wr_idx*64 +: 64] = bmem_wdata;
                mem_lines[bmem_addr] = wr_buf;
                wr_idx = (wr_idx + 1) % 4;
            end
            #1;
            r = next_rand();
            bmem_ready = (r[1:0] != 2'b00);
            bmem_rvalid = (rd_left > 0) && r[2];
            // junk on the data bus between beats
            bmem_rdata = bmem_rvalid ? rd_line[rd_idx*64 +: 64] : {r, ~r};
            for (int i = 0; i < num_ports; i++) begin
                if (got[i]) begin
                    served++;
                    req_read[i] = 1'b0;
                    req_write[i] = 1'b0;
                    // back-to-back while the order is checked and random idle time after
                    gap[i] = (served < order_len) ? 0 : int'(next_rand() % 6);
                end else if (!req_read[i] && !req_write[i] && issued < num_trans) begin
                    if (gap[i] > 0) gap[i]--;
                    else raise_request(i);
                end
            end
        end
        repeat (4) @(posedge clk);
        assert (cross_reads > 0)
            else report_failure("no read of a line last written by another port");
        if (check_failures == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            end_with_failure();
        end
    end

    always @(posedge clk) begin : compare_resp
        int p;
        mem_arb_pkg::line_t exp;
        p = -1;
        if (prev_rst) begin
            assert (resp == '0 && !bmem_read && !bmem_write)
                else report_failure("resp or a memory command active during reset");
        end
        prev_rst = rst;
        if (!rst) begin
            // held command and beat under back-pressure
            if (rd_stall) begin
                assert (bmem_read) else report_failure("bmem_read dropped before acceptance");
                assert (bmem_addr == stall_addr)
                    else report_mismatch("bmem_addr", 256'(stall_addr), 256'(bmem_addr));
            end
            if (wr_stall) begin
                assert (bmem_write) else report_failure("bmem_write dropped mid beat");
                assert (bmem_wdata == stall_beat)
                    else report_mismatch("bmem_wdata", 256'(stall_beat), 256'(bmem_wdata));
            end
            for (int i = 0; i < num_ports; i++) begin
                if (resp[i]) p = i;
            end
            if (p >= 0) begin
                assert ($countones(resp) == 1) else report_failure("several resp bits high");
                assert (req_read[p] || req_write[p])
                    else report_failure($sformatf("resp to port %0d with no request", p));
                assert (beats == 4) else report_mismatch("beat count", 256'(4), 256'(beats));
                if (resp_total < order_len) begin
                    assert (p == exp_port)
                        else report_mismatch("resp port", 256'(exp_port), 256'(p));
                    exp_port = (exp_port + 1) % num_ports;
                end
                if (req_read[p]) begin
                    exp = expected_line(req_addr[p]);
                    assert (resp_rdata == exp) else report_mismatch("resp_rdata", exp, resp_rdata);
                    assert (rd_cmd_addr == req_addr[p])
                        else report_mismatch("bmem_addr", 256'(req_addr[p]), 256'(rd_cmd_addr));
                    if (writer.exists(req_addr[p]) && writer[req_addr[p]] != p) begin
                        cross_reads++;
                    end
                end else begin
                    assert (wr_line == req_wdata[p])
                        else report_mismatch("bmem_wdata line", req_wdata[p], wr_line);
                    assert (wr_cmd_addr == req_addr[p])
                        else report_mismatch("bmem_addr", 256'(req_addr[p]), 256'(wr_cmd_addr));
                    shadow[req_addr[p]] = req_wdata[p];
                    writer[req_addr[p]] = p;
                end
                beats = 0;
                resp_total++;
            end
            if (bmem_read && bmem_ready) rd_cmd_addr = bmem_addr;
            if ((bmem_write && bmem_ready) || bmem_rvalid) begin
                assert (beats < 4) else report_failure("more than four beats in one burst");
                if (bmem_write) begin
                    wr_line[beats*64 +: 64] = bmem_wdata;
                    wr_cmd_addr = bmem_addr;
                end
                beats++;
            end
            rd_stall = bmem_read && !bmem_ready;
            wr_stall = bmem_write && !bmem_ready;
            stall_addr = bmem_addr;
            stall_beat = bmem_wdata;
        end
    end

    // worst case bound over the whole run
    initial begin : watchdog
        #(num_trans * cycles_per_trans * clk_period);
        $display("Timeout: %0d of %0d transactions answered in time", served, num_trans);
        end_with_failure();
    end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

// main memory arbiter, four cache miss ports onto one burst memory
module mem_arbiter #(
    parameter int num_ports = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // requester side, one entry per port
    input  wire logic [num_ports-1:0]   req_read,
    input  wire logic [num_ports-1:0]   req_write,
    input  wire mem_arb_pkg::addr_t     req_addr [num_ports],
    input  wire mem_arb_pkg::line_t     req_wdata [num_ports],
    output logic      [num_ports-1:0]   resp,
    output mem_arb_pkg::line_t          resp_rdata,

    // burst memory side
    output mem_arb_pkg::addr_t          bmem_addr,
    output logic                        bmem_read,
    output logic                        bmem_write,
    output mem_arb_pkg::beat_t          bmem_wdata,
    input  wire logic                   bmem_ready,
    input  wire mem_arb_pkg::beat_t     bmem_rdata,
    input  wire logic                   bmem_rvalid
);

    localparam int idx_w = $clog2(num_ports);

    logic [idx_w-1:0]       grant;
    logic                   beat_clear;
    logic                   beat_advance;
    logic                   last_beat;
    mem_arb_pkg::beat_idx_t beat_idx;

    // returned beat on reads, accepted beat on writes
    assign beat_advance = bmem_rvalid | (bmem_write & bmem_ready);

    rr_scheduler #(
        .num_ports(num_ports)
    ) u_sched (
        .clk         (clk),
        .rst         (rst),
        .req_read    (req_read),
        .req_write   (req_write),
        .bmem_ready  (bmem_ready),
        .last_beat   (last_beat),
        .beat_advance(beat_advance),
        .grant       (grant),
        .issue_read  (bmem_read),
        .burst_write (bmem_write),
        .beat_clear  (beat_clear),
        .resp        (resp)
    );

    beat_counter u_count (
        .clk      (clk),
        .rst      (rst),
        .clear    (beat_clear),
        .advance  (beat_advance),
        .beat_idx (beat_idx),
        .last_beat(last_beat)
    );

    // read data for the respond cycle
    line_assembler u_line (
        .clk       (clk),
        .rst       (rst),
        .clear     (beat_clear),
        .beat_valid(bmem_rvalid),
        .beat_idx  (beat_idx),
        .beat_data (bmem_rdata),
        .line      (resp_rdata)
    );

    request_path #(
        .num_ports(num_ports)
    ) u_req (
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .grant     (grant),
        .beat_idx  (beat_idx),
        .bmem_addr (bmem_addr),
        .bmem_wdata(bmem_wdata)
    );

endmodule

`default_nettype wire

/* logic/request_path.sv */
`timescale 1ns/1ns
`default_nettype none

// address and write data mux for the granted port
module request_path #(
    parameter int num_ports = 4
) (
    input  wire mem_arb_pkg::addr_t         req_addr [num_ports],
    input  wire mem_arb_pkg::line_t         req_wdata [num_ports],
    input  wire logic [$clog2(num_ports)-1:0] grant,
    input  wire mem_arb_pkg::beat_idx_t     beat_idx,
    output mem_arb_pkg::addr_t              bmem_addr,
    output mem_arb_pkg::beat_t              bmem_wdata
);

    localparam int addr_w = mem_arb_pkg::addr_w;
    localparam int beat_w = mem_arb_pkg::beat_w;
    localparam int offset_w = mem_arb_pkg::line_offset_w;

    mem_arb_pkg::addr_t sel_addr;
    mem_arb_pkg::line_t sel_line;
    int unsigned        base;

    // granted port's request
    assign sel_addr = req_addr[grant];
    assign sel_line = req_wdata[grant];

    // line aligned address to the memory
    assign bmem_addr = {sel_addr[addr_w-1:offset_w], offset_w'(0)};

    // current write beat, held until the counter moves on
    assign base = int'(beat_idx) * beat_w;
    assign bmem_wdata = sel_line[base +: beat_w];

    // requesters only ever ask for whole lines
    always_comb begin : offset_check
        assert final (sel_addr[offset_w-1:0] == '0)
            else $error("request_path: granted address %h not line aligned", sel_addr);
    end

endmodule

`default_nettype wire

/* logic/line_assembler.sv */
`timescale 1ns/1ns
`default_nettype none

// gathers returned read beats into one line
module line_assembler (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   clear,
    input  wire logic                   beat_valid,
    input  wire mem_arb_pkg::beat_idx_t beat_idx,
    input  wire mem_arb_pkg::beat_t     beat_data,
    output mem_arb_pkg::line_t          line
);

    localparam int beat_w = mem_arb_pkg::beat_w;

    // slot base for the incoming beat
    int unsigned base;

    assign base = int'(beat_idx) * beat_w;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            line <= '0;
        end else if (beat_valid) begin
            // beat 0 ends up in the low bits
            line[base +: beat_w] <= beat_data;
        end
    end

    // line only changes on rvalid, so it holds through respond

endmodule

`default_nettype wire

/* logic/beat_counter.sv */
`timescale 1ns/1ns
`default_nettype none

// beat position within the current burst, shared by reads and writes
module beat_counter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   clear,
    input  wire logic                   advance,
    output mem_arb_pkg::beat_idx_t      beat_idx,
    output logic                        last_beat
);

    // set once all beats of the line went through
    logic line_done;

    // final beat accepted or returned in this cycle
    assign last_beat = advance &&
        (beat_idx == mem_arb_pkg::beat_idx_t'(mem_arb_pkg::line_beats - 1));

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat_idx <= '0;
            line_done <= 1'b0;
        end else if (advance) begin
            // wraps back to 0 after the last beat
            beat_idx <= beat_idx + mem_arb_pkg::beat_idx_t'(1);
            if (last_beat) line_done <= 1'b1;
        end
    end

    // no extra beat until the next grant clears us
    assert property (@(posedge clk) disable iff (rst) line_done |-> !advance);

endmodule

`default_nettype wire

/* logic/rr_scheduler.sv */
`timescale 1ns/1ns
`default_nettype none

// round-robin grant FSM sequencing one read or write burst at a time
module rr_scheduler #(
    parameter int num_ports = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [num_ports-1:0]         req_read,
    input  wire logic [num_ports-1:0]         req_write,
    input  wire logic                         bmem_ready,
    input  wire logic                         last_beat,
    input  wire logic                         beat_advance,
    output logic      [$clog2(num_ports)-1:0] grant,
    output logic                              issue_read,
    output logic                              burst_write,
    output logic                              beat_clear,
    output logic      [num_ports-1:0]         resp
);

    localparam int idx_w = $clog2(num_ports);

    typedef enum logic [2:0] {
        idle,
        read_issue,
        read_wait,
        write_burst,
        respond
    } sched_state_t;

    sched_state_t state;
    sched_state_t state_next;

    // round-robin pointer to the first port to look at
    logic [idx_w-1:0] ptr;
    logic [idx_w-1:0] pick;
    logic             pick_valid;
    logic [num_ports-1:0] req_any;

    assign req_any = req_read | req_write;

    // first requester at or after ptr with wraparound
    always_comb begin : pick_port
        int unsigned cand;
        pick = ptr;
        pick_valid = 1'b0;
        // walk downward so the closest offset wins last
        for (int i = num_ports - 1; i >= 0; i--) begin
            cand = (int'(ptr) + i) % num_ports;
            if (req_any[cand]) begin
                pick = idx_w'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb begin : next_state
        state_next = state;
        case (state)
            idle: begin
                if (pick_valid) begin
                    state_next = req_read[pick] ? read_issue : write_burst;
                end
            end
            // command held through back-pressure
            read_issue: if (bmem_ready) state_next = read_wait;
            read_wait: if (beat_advance && last_beat) state_next = respond;
            write_burst: if (beat_advance && last_beat) state_next = respond;
            respond: state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            ptr <= '0;
            grant <= '0;
        end else begin
            state <= state_next;
            // grant latched once per transaction
            if (state == idle && pick_valid) grant <= pick;
            // move past the served port
            if (state == respond) begin
                ptr <= (int'(grant) == num_ports - 1) ? '0 : grant + 1'b1;
            end
        end
    end

    assign issue_read  = (state == read_issue);
    assign burst_write = (state == write_burst);
    // counter and line start fresh on every grant
    assign beat_clear  = (state == idle) && pick_valid;

    always_comb begin : resp_decode
        resp = '0;
        if (state == respond) resp[grant] = 1'b1;
    end

    // only the granted port sees a pulse
    assert property (@(posedge clk) disable iff (rst) $onehot0(resp));

    // never a read command during a write burst
    assert property (@(posedge clk) disable iff (rst) !(issue_read && burst_write));

endmodule

`default_nettype wire

/* logic/mem_arb_pkg.sv */
`default_nettype none

// shared widths and vector types for the memory arbiter
package mem_arb_pkg;

    // byte address width
    parameter int addr_w = 32;

    // one memory beat
    parameter int beat_w = 64;

    // beats per cache line
    parameter int line_beats = 4;

    // full line, beat 0 in the low bits
    parameter int line_w = line_beats * beat_w;

    // byte offset bits inside a line
    parameter int line_offset_w = 5;

    // byte address, line addresses have a zero offset
    typedef logic [addr_w-1:0] addr_t;

    // single 64-bit beat on the memory bus
    typedef logic [beat_w-1:0] beat_t;

    // one 256-bit cache line
    typedef logic [line_w-1:0] line_t;

    // beat position within a line
    typedef logic [$clog2(line_beats)-1:0] beat_idx_t;

endpackage

`default_nettype wire
